//--- src/core_macros.svh
/*
 * Core-wide constants for the machine-mode CSR block.
 * Register width, trap vector after reset and misa contents.
 */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ----------------------------------------
// Register width of the hart
`define XLEN 64

// Direct-mode trap vector after reset
`define MTVEC_RESET 64'h0000_0000_C000_0000

// MXL=2 (RV64) with I at bit 8 and M at bit 12
`define MISA_VALUE 64'h8000_0000_0000_1100

`endif

//--- src/csr_pkg.sv
/*
 * CSR access types: supported addresses, access operations,
 * pipeline request, write enables and register read views.
 */
`include "core_macros.svh"

package csr_pkg;

    typedef enum logic [11:0] {
        addr_mstatus       = 12'h300,
        addr_misa          = 12'h301,
        addr_mie           = 12'h304,
        addr_mtvec         = 12'h305,
        addr_mcountinhibit = 12'h320,
        addr_mscratch      = 12'h340,
        addr_mepc          = 12'h341,
        addr_mcause        = 12'h342,
        addr_mtval         = 12'h343,
        addr_mip           = 12'h344,
        addr_mcycle        = 12'hB00,
        addr_minstret      = 12'hB02,
        addr_cycle         = 12'hC00,
        addr_instret       = 12'hC02
    } csr_addr_e;

    typedef enum logic [1:0] {
        op_write,
        op_set,
        op_clear
    } csr_op_e;

    // Access from the pipeline
    typedef struct packed {
        logic              en;
        logic              wr;
        csr_op_e           op;
        logic [11:0]       addr;
        logic [`XLEN-1:0]  wdata;
    } csr_req_t;

    // One strobe per writable CSR
    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mcountinhibit;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle;
        logic minstret;
    } csr_wen_t;

    // Read view of every readable CSR
    typedef struct packed {
        logic [`XLEN-1:0] mstatus;
        logic [`XLEN-1:0] misa;
        logic [`XLEN-1:0] mie;
        logic [`XLEN-1:0] mtvec;
        logic [`XLEN-1:0] mcountinhibit;
        logic [`XLEN-1:0] mscratch;
        logic [`XLEN-1:0] mepc;
        logic [`XLEN-1:0] mcause;
        logic [`XLEN-1:0] mtval;
        logic [`XLEN-1:0] mip;
        logic [`XLEN-1:0] mcycle;
        logic [`XLEN-1:0] minstret;
    } csr_view_t;

    // New register value for a write, set or clear access
    function automatic logic [`XLEN-1:0] csr_merge(
        input logic [`XLEN-1:0] old_val,
        input logic [`XLEN-1:0] wdata,
        input csr_op_e          op
    );
        case (op)
            op_set:   csr_merge = old_val | wdata;
            op_clear: csr_merge = old_val & ~wdata;
            default:  csr_merge = wdata;
        endcase
    endfunction

endpackage

//--- src/trap_pkg.sv
/*
 * Trap and interrupt types: the trap event from the pipeline,
 * synchronous exception codes and the interrupt line bundle.
 */
`include "core_macros.svh"

package trap_pkg;

    typedef struct packed {
        logic             cpu;    // Synchronous exception
        logic             intr;   // Interrupt taken
        logic [5:0]       cause;
        logic [`XLEN-1:0] mtval;
        logic [`XLEN-1:0] pc;
    } trap_t;

    typedef enum logic [5:0] {
        cause_ialign   = 6'd0,
        cause_iaccess  = 6'd1,
        cause_iopcode  = 6'd2,
        cause_breakpt  = 6'd3,
        cause_ldalign  = 6'd4,
        cause_ldaccess = 6'd5,
        cause_stalign  = 6'd6,
        cause_staccess = 6'd7,
        cause_ecallm   = 6'd11
    } cause_e;

    // Pending inputs and enable outputs share this layout
    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_t;

endpackage

//--- src/csr_access.sv
/*
 * CSR address decode. Forms the per-register write strobes,
 * muxes the read data and flags writes to unmapped addresses.
 */
`include "core_macros.svh"

module csr_access (
    input  csr_pkg::csr_req_t  csr_req,
    input  csr_pkg::csr_view_t view,
    output csr_pkg::csr_wen_t  wen,
    output logic [`XLEN-1:0]   csr_rdata,
    output logic               csr_error
);

    import csr_pkg::*;

    typedef struct packed {
        logic mstatus;
        logic misa;
        logic mie;
        logic mtvec;
        logic mcountinhibit;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mip;
        logic mcycle;
        logic minstret;
        logic cycle;
        logic instret;
    } rd_sel_t;

    rd_sel_t sel;    // One-hot, zero when idle or unmapped
    logic    wr_ok;

    // ----------------------------------------
    // Address decode
    always_comb begin
        sel = '0;
        case (csr_req.addr)
            addr_mstatus:       sel.mstatus       = csr_req.en;
            addr_misa:          sel.misa          = csr_req.en;
            addr_mie:           sel.mie           = csr_req.en;
            addr_mtvec:         sel.mtvec         = csr_req.en;
            addr_mcountinhibit: sel.mcountinhibit = csr_req.en;
            addr_mscratch:      sel.mscratch      = csr_req.en;
            addr_mepc:          sel.mepc          = csr_req.en;
            addr_mcause:        sel.mcause        = csr_req.en;
            addr_mtval:         sel.mtval         = csr_req.en;
            addr_mip:           sel.mip           = csr_req.en;
            addr_mcycle:        sel.mcycle        = csr_req.en;
            addr_minstret:      sel.minstret      = csr_req.en;
            addr_cycle:         sel.cycle         = csr_req.en;
            addr_instret:       sel.instret       = csr_req.en;
            default:            sel               = '0;
        endcase
    end

    assign wr_ok = csr_req.en && csr_req.wr;

    // Read-only CSRs get no strobe, so writes there are dropped
    always_comb begin
        wen               = '0;
        wen.mstatus       = wr_ok && sel.mstatus;
        wen.mie           = wr_ok && sel.mie;
        wen.mtvec         = wr_ok && sel.mtvec;
        wen.mcountinhibit = wr_ok && sel.mcountinhibit;
        wen.mscratch      = wr_ok && sel.mscratch;
        wen.mepc          = wr_ok && sel.mepc;
        wen.mcause        = wr_ok && sel.mcause;
        wen.mtval         = wr_ok && sel.mtval;
        wen.mcycle        = wr_ok && sel.mcycle;
        wen.minstret      = wr_ok && sel.minstret;
    end

    assign csr_error = wr_ok && ~|sel;   // Write with no matching address

    // ----------------------------------------
    // Read data, AND-OR mux
    assign csr_rdata =
        ({`XLEN{sel.mstatus}}       & view.mstatus)       |
        ({`XLEN{sel.misa}}          & view.misa)          |
        ({`XLEN{sel.mie}}           & view.mie)           |
        ({`XLEN{sel.mtvec}}         & view.mtvec)         |
        ({`XLEN{sel.mcountinhibit}} & view.mcountinhibit) |
        ({`XLEN{sel.mscratch}}      & view.mscratch)      |
        ({`XLEN{sel.mepc}}          & view.mepc)          |
        ({`XLEN{sel.mcause}}        & view.mcause)        |
        ({`XLEN{sel.mtval}}         & view.mtval)         |
        ({`XLEN{sel.mip}}           & view.mip)           |
        ({`XLEN{sel.mcycle}}        & view.mcycle)        |
        ({`XLEN{sel.minstret}}      & view.minstret)      |
        ({`XLEN{sel.cycle}}         & view.mcycle)        |   // User alias
        ({`XLEN{sel.instret}}       & view.minstret);         // User alias

endmodule

//--- src/trap_status_regs.sv
/*
 * Trap state: mstatus MIE/MPIE, mepc, mcause and mtval.
 * Trap entry wins over MRET, which wins over a CSR write.
 */
`include "core_macros.svh"

module trap_status_regs (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  csr_pkg::csr_wen_t  wen,
    input  csr_pkg::csr_req_t  csr_req,
    input  trap_pkg::trap_t    trap,
    input  logic               exec_mret,
    output logic [`XLEN-1:0]   mstatus_view,
    output logic [`XLEN-1:0]   mepc_view,
    output logic [`XLEN-1:0]   mcause_view,
    output logic [`XLEN-1:0]   mtval_view,
    output logic               mstatus_mie
);

    import csr_pkg::*;

    logic             reg_mie;
    logic             reg_mpie;
    logic [`XLEN-1:1] reg_mepc;     // Bit 0 always reads zero
    logic [`XLEN-1:0] reg_mcause;
    logic [`XLEN-1:0] reg_mtval;

    logic             trap_any;
    logic [`XLEN-1:0] n_mstatus;
    logic [`XLEN-1:0] n_mepc;

    assign trap_any  = trap.cpu || trap.intr;
    assign n_mstatus = csr_merge(mstatus_view, csr_req.wdata, csr_req.op);
    assign n_mepc    = csr_merge(mepc_view, csr_req.wdata, csr_req.op);

    // ----------------------------------------
    // mstatus
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reg_mie  <= 1'b0;
            reg_mpie <= 1'b0;
        end else if (trap_any) begin
            reg_mie  <= 1'b0;        // Interrupts off in the handler
            reg_mpie <= reg_mie;
        end else if (exec_mret) begin
            reg_mie  <= reg_mpie;
            reg_mpie <= 1'b1;
        end else if (wen.mstatus) begin
            reg_mie  <= n_mstatus[3];
            reg_mpie <= n_mstatus[7];
        end
    end

    assign mstatus_view = {{(`XLEN-8){1'b0}}, reg_mpie, 3'b000, reg_mie, 3'b000};
    assign mstatus_mie  = reg_mie;

    // ----------------------------------------
    // mepc, mcause, mtval
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reg_mepc <= '0;
        end else if (trap_any) begin
            reg_mepc <= trap.pc[`XLEN-1:1];
        end else if (wen.mepc) begin
            reg_mepc <= n_mepc[`XLEN-1:1];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reg_mcause <= '0;
        end else if (trap_any) begin
            reg_mcause <= {trap.intr, {(`XLEN-7){1'b0}}, trap.cause};  // Bit 63 marks interrupts
        end else if (wen.mcause) begin
            reg_mcause <= csr_merge(reg_mcause, csr_req.wdata, csr_req.op);
        end
    end

    // Interrupt entry leaves mtval alone
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reg_mtval <= '0;
        end else if (trap.cpu) begin
            reg_mtval <= trap.mtval;
        end else if (wen.mtval) begin
            reg_mtval <= csr_merge(reg_mtval, csr_req.wdata, csr_req.op);
        end
    end

    assign mepc_view   = {reg_mepc, 1'b0};
    assign mcause_view = reg_mcause;
    assign mtval_view  = reg_mtval;

endmodule

//--- src/machine_regs.sv
/*
 * Machine configuration registers: mie, mtvec, mscratch
 * and mcountinhibit, each masked to its implemented fields.
 */
`include "core_macros.svh"

module machine_regs (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  csr_pkg::csr_wen_t  wen,
    input  csr_pkg::csr_req_t  csr_req,
    output trap_pkg::irq_t     irq_enable,
    output logic [`XLEN-1:0]   mie_view,
    output logic [`XLEN-1:0]   mtvec_view,
    output logic [`XLEN-1:0]   mscratch_view,
    output logic [`XLEN-1:0]   inhibit_view,
    output logic               inhibit_cy,
    output logic               inhibit_ir
);

    import csr_pkg::*;

    localparam logic [`XLEN-1:0] MTVEC_RST = `MTVEC_RESET;

    logic [`XLEN-1:2] reg_mtvec_base;    // Direct mode only
    logic [`XLEN-1:0] reg_mscratch;
    logic [`XLEN-1:0] n_mie;
    logic [`XLEN-1:0] n_mtvec;
    logic [`XLEN-1:0] n_inhibit;

    assign n_mie     = csr_merge(mie_view, csr_req.wdata, csr_req.op);
    assign n_mtvec   = csr_merge(mtvec_view, csr_req.wdata, csr_req.op);
    assign n_inhibit = csr_merge(inhibit_view, csr_req.wdata, csr_req.op);

    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            irq_enable     <= '0;
            reg_mtvec_base <= MTVEC_RST[`XLEN-1:2];
            reg_mscratch   <= '0;
            inhibit_cy     <= 1'b0;
            inhibit_ir     <= 1'b0;
        end else begin
            if (wen.mie) begin
                irq_enable.meip <= n_mie[11];
                irq_enable.mtip <= n_mie[7];
                irq_enable.msip <= n_mie[3];
            end
            if (wen.mtvec) begin
                reg_mtvec_base <= n_mtvec[`XLEN-1:2];
            end
            if (wen.mscratch) begin
                reg_mscratch <= csr_merge(reg_mscratch, csr_req.wdata, csr_req.op);
            end
            if (wen.mcountinhibit) begin
                inhibit_cy <= n_inhibit[0];
                inhibit_ir <= n_inhibit[2];   // No time counter at bit 1
            end
        end
    end

    assign mie_view      = {{(`XLEN-12){1'b0}}, irq_enable.meip, 3'b000,
                            irq_enable.mtip, 3'b000, irq_enable.msip, 3'b000};
    assign mtvec_view    = {reg_mtvec_base, 2'b00};
    assign mscratch_view = reg_mscratch;
    assign inhibit_view  = {{(`XLEN-3){1'b0}}, inhibit_ir, 1'b0, inhibit_cy};

endmodule

//--- src/hart_counters.sv
/*
 * Cycle and retired-instruction counters. A CSR write loads
 * the merged value in place of that cycle's increment.
 */
`include "core_macros.svh"

module hart_counters (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  csr_pkg::csr_wen_t  wen,
    input  csr_pkg::csr_req_t  csr_req,
    input  logic               instr_retired,
    input  logic               inhibit_cy,
    input  logic               inhibit_ir,
    output logic [`XLEN-1:0]   cycle_count,
    output logic [`XLEN-1:0]   instret_count
);

    import csr_pkg::*;

    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cycle_count <= '0;
        end else if (wen.mcycle) begin
            cycle_count <= csr_merge(cycle_count, csr_req.wdata, csr_req.op);
        end else if (!inhibit_cy) begin
            cycle_count <= cycle_count + 1'b1;   // Free running
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            instret_count <= '0;
        end else if (wen.minstret) begin
            instret_count <= csr_merge(instret_count, csr_req.wdata, csr_req.op);
        end else if (instr_retired && !inhibit_ir) begin
            instret_count <= instret_count + 1'b1;
        end
    end

endmodule

//--- src/core_csrs.sv
/*
 * Machine-mode CSR block of an RV64 hart. Wires the access
 * decoder to the trap, configuration and counter registers.
 */
`include "core_macros.svh"

module core_csrs (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  csr_pkg::csr_req_t   csr_req,
    input  trap_pkg::trap_t     trap,
    input  logic                exec_mret,
    input  logic                instr_retired,
    input  trap_pkg::irq_t      irq_pending,
    output logic [`XLEN-1:0]    csr_rdata,
    output logic                csr_error,
    output logic [`XLEN-1:0]    csr_mepc,
    output logic [`XLEN-1:0]    csr_mtvec,
    output logic                mstatus_mie,
    output trap_pkg::irq_t      irq_enable
);

    import csr_pkg::*;

    wire csr_view_t view;
    csr_wen_t       wen;
    logic           inhibit_cy;
    logic           inhibit_ir;

    // ----------------------------------------
    // Constant and input-driven views
    assign view.misa = `MISA_VALUE;
    assign view.mip  = {{(`XLEN-12){1'b0}}, irq_pending.meip, 3'b000,
                        irq_pending.mtip, 3'b000, irq_pending.msip, 3'b000};

    assign csr_mepc  = view.mepc;
    assign csr_mtvec = view.mtvec;

    csr_access u_access (
        .csr_req   (csr_req),
        .view      (view),
        .wen       (wen),
        .csr_rdata (csr_rdata),
        .csr_error (csr_error)
    );

    trap_status_regs u_trap_regs (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .wen          (wen),
        .csr_req      (csr_req),
        .trap         (trap),
        .exec_mret    (exec_mret),
        .mstatus_view (view.mstatus),
        .mepc_view    (view.mepc),
        .mcause_view  (view.mcause),
        .mtval_view   (view.mtval),
        .mstatus_mie  (mstatus_mie)
    );

    machine_regs u_machine_regs (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .wen           (wen),
        .csr_req       (csr_req),
        .irq_enable    (irq_enable),
        .mie_view      (view.mie),
        .mtvec_view    (view.mtvec),
        .mscratch_view (view.mscratch),
        .inhibit_view  (view.mcountinhibit),
        .inhibit_cy    (inhibit_cy),
        .inhibit_ir    (inhibit_ir)
    );

    hart_counters u_counters (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .wen           (wen),
        .csr_req       (csr_req),
        .instr_retired (instr_retired),
        .inhibit_cy    (inhibit_cy),
        .inhibit_ir    (inhibit_ir),
        .cycle_count   (view.mcycle),
        .instret_count (view.minstret)
    );

endmodule

//--- dv/tb_core_csrs.sv
/*
 * Testbench for the machine-mode CSR block. Keeps its own model
 * of every CSR and checks read data, error and side outputs.
 */
`include "core_macros.svh"

module tb_core_csrs;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;
    import trap_pkg::*;

    localparam int CYCLE_LIMIT = 2000;   // Stimulus runs a few hundred cycles

    logic             g_clk = 1'b0;
    logic             g_resetn;
    csr_req_t         csr_req;
    trap_t            trap;
    logic             exec_mret;
    logic             instr_retired;
    irq_t             irq_pending;
    logic [`XLEN-1:0] csr_rdata;
    logic             csr_error;
    logic [`XLEN-1:0] csr_mepc;
    logic [`XLEN-1:0] csr_mtvec;
    logic             mstatus_mie;
    irq_t             irq_enable;

    // Model of the CSR state
    logic             m_mie;
    logic             m_mpie;
    logic [`XLEN-1:0] m_mepc;
    logic [`XLEN-1:0] m_mcause;
    logic [`XLEN-1:0] m_mtval;
    logic [`XLEN-1:0] m_ie;
    logic [`XLEN-1:0] m_mtvec;
    logic [`XLEN-1:0] m_mscratch;
    logic [`XLEN-1:0] m_inhibit;
    logic [`XLEN-1:0] m_cycle;
    logic [`XLEN-1:0] m_instret;

    integer      seed = 3991;
    int          run_cycles = 0;
    logic [11:0] cfg_addrs [4] = '{addr_mscratch, addr_mie, addr_mtvec, addr_mcountinhibit};

    core_csrs dut0 (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .csr_req       (csr_req),
        .trap          (trap),
        .exec_mret     (exec_mret),
        .instr_retired (instr_retired),
        .irq_pending   (irq_pending),
        .csr_rdata     (csr_rdata),
        .csr_error     (csr_error),
        .csr_mepc      (csr_mepc),
        .csr_mtvec     (csr_mtvec),
        .mstatus_mie   (mstatus_mie),
        .irq_enable    (irq_enable)
    );

    always #4 g_clk = ~g_clk;   // 8 ns period

    // ----------------------------------------
    // Reference rules
    function automatic logic [`XLEN-1:0] merged_value(input logic [`XLEN-1:0] old_val,
                                                      input logic [`XLEN-1:0] wdata,
                                                      input csr_op_e op);
        if (op == op_set)
            return old_val | wdata;
        else if (op == op_clear)
            return old_val & ~wdata;
        return wdata;
    endfunction

    function automatic logic is_mapped(input logic [11:0] addr);
        case (addr)
            12'h300, 12'h301, 12'h304, 12'h305, 12'h320, 12'h340, 12'h341,
            12'h342, 12'h343, 12'h344, 12'hB00, 12'hB02, 12'hC00, 12'hC02:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] expected_read(input logic [11:0] addr);
        case (addr)
            12'h300: return ({{56{1'b0}}, m_mpie, 7'b0} | {{60{1'b0}}, m_mie, 3'b0});
            12'h301: return `MISA_VALUE;
            12'h304: return m_ie;
            12'h305: return m_mtvec;
            12'h320: return m_inhibit;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h344: return {52'b0, irq_pending.meip, 3'b0, irq_pending.mtip, 3'b0,
                             irq_pending.msip, 3'b0};
            12'hB00, 12'hC00: return m_cycle;
            12'hB02, 12'hC02: return m_instret;
            default: return '0;   // Unmapped
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
            $display("Errors found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // Model update at each rising edge
    always @(posedge g_clk) begin : model_update
        logic             wr_hit;
        logic             old_mie;
        logic [`XLEN-1:0] nv;
        if (!g_resetn) begin
            m_mie      = 1'b0;
            m_mpie     = 1'b0;
            m_mepc     = '0;
            m_mcause   = '0;
            m_mtval    = '0;
            m_ie       = '0;
            m_mtvec    = `MTVEC_RESET;
            m_mscratch = '0;
            m_inhibit  = '0;
            m_cycle    = '0;
            m_instret  = '0;
        end else begin
            wr_hit  = csr_req.en && csr_req.wr;
            nv      = merged_value(expected_read(csr_req.addr), csr_req.wdata, csr_req.op);
            old_mie = m_mie;
            // Counters see the inhibit bits from before this edge
            if (wr_hit && csr_req.addr == addr_mcycle)
                m_cycle = nv;
            else if (!m_inhibit[0])
                m_cycle = m_cycle + 1;
            if (wr_hit && csr_req.addr == addr_minstret)
                m_instret = nv;
            else if (instr_retired && !m_inhibit[2])
                m_instret = m_instret + 1;
            if (trap.cpu || trap.intr) begin
                m_mie    = 1'b0;
                m_mpie   = old_mie;
                m_mepc   = trap.pc & ~64'h1;
                m_mcause = {trap.intr, 57'b0, trap.cause};
            end else begin
                if (exec_mret) begin
                    m_mie  = m_mpie;
                    m_mpie = 1'b1;
                end else if (wr_hit && csr_req.addr == addr_mstatus) begin
                    m_mie  = nv[3];
                    m_mpie = nv[7];
                end
                if (wr_hit && csr_req.addr == addr_mepc)
                    m_mepc = nv & ~64'h1;
                if (wr_hit && csr_req.addr == addr_mcause)
                    m_mcause = nv;
            end
            if (trap.cpu)
                m_mtval = trap.mtval;
            else if (wr_hit && csr_req.addr == addr_mtval)
                m_mtval = nv;
            if (wr_hit && csr_req.addr == addr_mie)
                m_ie = nv & 64'h888;
            if (wr_hit && csr_req.addr == addr_mtvec)
                m_mtvec = nv & ~64'h3;
            if (wr_hit && csr_req.addr == addr_mscratch)
                m_mscratch = nv;
            if (wr_hit && csr_req.addr == addr_mcountinhibit)
                m_inhibit = nv & 64'h5;   // CY and IR only
        end
    end

    // Compare at the falling edge while inputs are stable
    always @(negedge g_clk) begin
        if (g_resetn) begin
            if (csr_req.en)
                check_value("csr_rdata", csr_rdata, expected_read(csr_req.addr));
            check_value("csr_error", csr_error,
                        csr_req.en && csr_req.wr && !is_mapped(csr_req.addr));
            check_value("csr_mepc", csr_mepc, m_mepc);
            check_value("csr_mtvec", csr_mtvec, m_mtvec);
            check_value("mstatus_mie", mstatus_mie, m_mie);
            check_value("irq_enable", irq_enable, {m_ie[11], m_ie[7], m_ie[3]});
        end
    end

    always @(posedge g_clk) begin
        run_cycles++;
        if (run_cycles >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "Cycle limit reached");
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    function automatic logic [`XLEN-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic drive_idle();
        csr_req       = '0;
        trap          = '0;
        exec_mret     = 1'b0;
        instr_retired = 1'b0;
    endtask

    task automatic csr_cycle(input logic [11:0] addr, input logic wr, input csr_op_e op,
                             input logic [`XLEN-1:0] wdata);
        @(posedge g_clk);
        #1;
        drive_idle();
        csr_req.en    = 1'b1;
        csr_req.wr    = wr;
        csr_req.op    = op;
        csr_req.addr  = addr;
        csr_req.wdata = wdata;
    endtask

    task automatic idle_cycle();
        @(posedge g_clk);
        #1;
        drive_idle();
    endtask

    initial begin : stimulus
        logic [11:0]      a;
        logic [`XLEN-1:0] v;
        drive_idle();
        irq_pending = '0;
        g_resetn    = 1'b0;
        repeat (10) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        csr_cycle(addr_mtvec, 1'b0, op_write, '0);     // Reset vector
        csr_cycle(addr_mstatus, 1'b0, op_write, '0);

        // Random write, set and clear on the configuration CSRs
        for (int i = 0; i < 48; i++) begin
            a = cfg_addrs[{$random(seed)} % 4];
            csr_cycle(a, 1'b1, csr_op_e'({$random(seed)} % 3), random_word());
            csr_cycle(a, 1'b0, op_write, '0);
        end
        csr_cycle(addr_mcountinhibit, 1'b1, op_write, '0);

        // cpu trap with MIE set, then an interrupt
        csr_cycle(addr_mstatus, 1'b1, op_set, 64'h8);
        idle_cycle();
        trap.cpu   = 1'b1;
        trap.cause = {$random(seed)} % 8;
        trap.pc    = random_word();
        trap.mtval = random_word();
        csr_cycle(addr_mepc, 1'b0, op_write, '0);
        csr_cycle(addr_mcause, 1'b0, op_write, '0);
        csr_cycle(addr_mtval, 1'b0, op_write, '0);
        csr_cycle(addr_mstatus, 1'b0, op_write, '0);
        idle_cycle();
        trap.intr  = 1'b1;
        trap.cause = 6'd7;
        trap.pc    = random_word();
        trap.mtval = random_word();   // Must not reach mtval
        csr_cycle(addr_mcause, 1'b0, op_write, '0);
        csr_cycle(addr_mtval, 1'b0, op_write, '0);

        // MRET, then the priority cases
        repeat (2) begin
            idle_cycle();
            exec_mret = 1'b1;
            csr_cycle(addr_mstatus, 1'b0, op_write, '0);
        end
        csr_cycle(addr_mstatus, 1'b1, op_clear, 64'h88);
        exec_mret = 1'b1;             // Write is lost
        csr_cycle(addr_mstatus, 1'b0, op_write, '0);
        csr_cycle(addr_mepc, 1'b1, op_write, random_word());
        trap.cpu   = 1'b1;
        trap.cause = cause_ecallm;
        trap.pc    = random_word();
        csr_cycle(addr_mepc, 1'b0, op_write, '0);

        // Counters and their aliases
        v = random_word();
        csr_cycle(addr_mcycle, 1'b1, op_write, v);
        for (int i = 0; i < 8; i++)
            csr_cycle((i % 2) ? addr_cycle : addr_mcycle, 1'b0, op_write, '0);
        csr_cycle(addr_minstret, 1'b1, op_write, random_word());
        for (int i = 0; i < 16; i++) begin
            csr_cycle((i % 2) ? addr_instret : addr_minstret, 1'b0, op_write, '0);
            instr_retired = $random(seed);
        end
        csr_cycle(addr_mcountinhibit, 1'b1, op_write, 64'h5);
        for (int i = 0; i < 6; i++) begin
            csr_cycle((i % 2) ? addr_minstret : addr_mcycle, 1'b0, op_write, '0);
            instr_retired = 1'b1;
        end
        csr_cycle(addr_mcountinhibit, 1'b1, op_write, '0);

        // misa, mip, read-only and unmapped addresses
        csr_cycle(addr_misa, 1'b0, op_write, '0);
        csr_cycle(addr_misa, 1'b1, op_write, random_word());
        csr_cycle(addr_cycle, 1'b1, op_write, random_word());
        csr_cycle(addr_mcycle, 1'b0, op_write, '0);    // Alias write was dropped
        for (int i = 0; i < 4; i++) begin
            csr_cycle(addr_mip, 1'b0, op_write, '0);
            irq_pending = $random(seed);
        end
        csr_cycle(12'h7C0, 1'b1, op_write, random_word());
        csr_cycle(12'h7C0, 1'b0, op_write, '0);
        csr_cycle(addr_mscratch, 1'b0, op_write, '0);
        idle_cycle();
        @(negedge g_clk);
        $display("No errors");
        $finish;
    end

endmodule

//--- core_csrs.f
+incdir+src
src/csr_pkg.sv
src/trap_pkg.sv
src/csr_access.sv
src/trap_status_regs.sv
src/machine_regs.sv
src/hart_counters.sv
src/core_csrs.sv
dv/tb_core_csrs.sv
